// ==== verif/csr_cases.txt ====
# op wid adr data exp_data exp_err (hex)
# R read, W write, F fpu flags, C commit pulses, M frm port, Y mcycle rising
R 0 F11 0 00000000 0
R 0 F12 0 00000001 0
R 0 F13 0 00000001 0
R 0 301 0 40001120 0
R 0 CC2 0 00000002 0
R 0 FC0 0 00000004 0
R 0 FC1 0 00000004 0
R 0 FC2 0 00000003 0
R 2 CC1 0 00000002 0
W 1 002 5 0 0
W 2 001 1B 0 0
W 3 003 E7 0 0
R 1 002 0 00000005 0
R 1 001 0 00000000 0
R 2 001 0 0000001B 0
R 3 003 0 000000E7 0
R 1 003 0 000000A0 0
M 1 0 0 5 0
M 3 0 0 7 0
W 0 001 4 0 0
F 0 0 3 0 0
F 2 0 4 0 0
R 0 001 0 00000007 0
R 2 001 0 0000001F 0
R 1 001 0 00000000 0
W 0 001 0 0 0
R 0 001 0 00000000 0
C 0 0 5 0 0
R 0 B02 0 00000005 0
R 0 B82 0 00000000 0
Y 0 B00 0 0 0
R 2 CC4 0 00000003 0
R 1 CC4 0 0000000A 0
R 0 CC3 0 0000000B 0
R 0 300 0 00000000 0
W 0 305 DEADBEEF 0 0
R 0 305 0 00000000 0
R 0 7FF 0 00000000 1
W 0 F11 1 0 1
R 0 F11 0 00000000 0

// ==== flist.f ====
src/csr_pkg.sv
src/csr_counters.sv
src/fcsr_bank.sv
src/csr_read_mux.sv
src/csr_ctrl.sv
src/csr_unit.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?=
VFLAGS    ?= --binary --timing --assert

SRCS  := $(shell grep -v '^+' $(FLIST))
CASES := verif/csr_cases.txt
BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(CASES)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^No errors$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/csr_unit_tb.sv ====
// CSR unit testbench
`timescale 1ns/1ps

module csr_unit_tb;

    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;
    localparam int WAIT_LIMIT  = 20;

    logic                                  clk = 1'b0;
    logic                                  reset;
    csr_pkg::csr_req_t                     bus_req;
    csr_pkg::csr_rsp_t                     bus_rsp;
    csr_pkg::fpu_flags_t                   fpu_flags;
    logic [csr_pkg::WID_BITS-1:0]          frm_wid;
    logic [csr_pkg::FRM_BITS-1:0]          frm;
    logic                                  commit;
    logic [NUM_WARPS-1:0]                  active_warps;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] thread_masks;

    integer seed = 32'hd95a_1d4b;
    int     errors;
    int     checks;
    int     cases;
    bit     timed_out;

    csr_unit #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_THREADS  (NUM_THREADS),
        .CORE_ID      (2),
        .NUM_CORES    (3)
    ) UUT (
        .clk          (clk),
        .reset        (reset),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .fpu_flags    (fpu_flags),
        .frm_wid      (frm_wid),
        .frm          (frm),
        .commit       (commit),
        .active_warps (active_warps),
        .thread_masks (thread_masks)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected, inout bit bad);
        checks++;
        assert (got == expected) else begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            errors++;
            bad = 1'b1;
        end
    endtask

    // One Wishbone classic access held until ack or err
    task automatic bus_access(input logic we, input logic [7:0] wid,
                              input logic [11:0] adr, input logic [31:0] dat,
                              output csr_pkg::csr_rsp_t rsp);
        int waited;
        waited = 0;
        @(negedge clk);
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.wid = wid;
        bus_req.adr = adr;
        bus_req.dat = dat;
        do begin
            @(negedge clk);
            waited++;
        end while (!bus_rsp.ack && !bus_rsp.err && waited < WAIT_LIMIT);
        rsp = bus_rsp;
        if (!bus_rsp.ack && !bus_rsp.err) begin
            $display("Timeout waiting for ack or err at address %h", adr);
            errors++;
            timed_out = 1'b1;
        end
        bus_req.cyc = 1'b0;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
    endtask

    task automatic run_case(input logic [7:0] op, input logic [7:0] wid,
                            input logic [11:0] adr, input logic [31:0] dat,
                            input logic [31:0] exp_dat, input logic exp_err);
        csr_pkg::csr_rsp_t rsp;
        logic [31:0]       first;
        bit                bad;
        bad = 1'b0;
        case (op)
            "R", "W": begin
                bus_access(op == "W", wid, adr, dat, rsp);
                check_value("bus_rsp.err", 32'(rsp.err), 32'(exp_err), bad);
                check_value("bus_rsp.ack", 32'(rsp.ack), 32'(!exp_err), bad);
                if (op == "R" && !exp_err) begin
                    check_value("bus_rsp.dat", rsp.dat, exp_dat, bad);
                end
            end
            "F": begin
                @(negedge clk);
                fpu_flags.valid  = 1'b1;
                fpu_flags.wid    = wid;
                fpu_flags.fflags = dat[4:0];
                @(negedge clk);
                fpu_flags.valid  = 1'b0;
            end
            "C": begin
                repeat (dat) begin
                    @(negedge clk);
                    commit = 1'b1;
                end
                @(negedge clk);
                commit = 1'b0;
            end
            "M": begin
                @(negedge clk);
                frm_wid = wid;
                @(negedge clk);
                check_value("frm", 32'(frm), exp_dat, bad);
            end
            "Y": begin
                // Back to back reads must see the counter move
                bus_access(1'b0, wid, adr, 32'h0, rsp);
                first = rsp.dat;
                bus_access(1'b0, wid, adr, 32'h0, rsp);
                checks++;
                assert (rsp.dat > first) else begin
                    $display("Fail bus_rsp.dat: second %h not above first %h", rsp.dat, first);
                    errors++;
                    bad = 1'b1;
                end
            end
            default: begin
                $display("Unknown operation %c in case %0d", op, cases);
                errors++;
                bad = 1'b1;
            end
        endcase
        $display("Case %0d %c wid %h adr %h %s", cases, op, wid, adr,
                 bad ? "failed" : "passed");
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [7:0]  op;
        logic [7:0]  wid;
        logic [11:0] adr;
        logic [31:0] dat;
        logic [31:0] exp_dat;
        logic        exp_err;
        errors       = 0;
        checks       = 0;
        cases        = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        bus_req      = '0;
        fpu_flags    = '0;
        frm_wid      = '0;
        commit       = 1'b0;
        active_warps = 4'b1011;
        thread_masks = 16'hC3A5;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("verif/csr_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, wid, adr, dat, exp_dat, exp_err);
                // Comment and blank lines do not parse fully
                if (n == 6) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    cases++;
                    run_case(op, wid, adr, dat, exp_dat, exp_err);
                end
            end
            $fclose(fd);
        end
        if (cases == 0) begin
            $display("No cases were run");
            errors++;
        end

        $display("Cases %0d, checks %0d, errors %0d", cases, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src/csr_unit.sv ====
// GPU core CSR unit
`timescale 1ns/1ps

module csr_unit #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4,
    parameter int CORE_ID     = 0,
    parameter int NUM_CORES   = 1
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  csr_pkg::csr_req_t                      bus_req,
    output csr_pkg::csr_rsp_t                      bus_rsp,
    input  csr_pkg::fpu_flags_t                    fpu_flags,
    input  logic [csr_pkg::WID_BITS-1:0]           frm_wid,
    output logic [csr_pkg::FRM_BITS-1:0]           frm,
    input  logic                                   commit,
    input  logic [NUM_WARPS-1:0]                   active_warps,
    input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0]  thread_masks
);

    csr_pkg::csr_sel_e               sel;
    csr_pkg::word_t                  rdata;
    logic                            fcsr_wr_en;
    csr_pkg::csr_sel_e               fcsr_wr_sel;
    logic [csr_pkg::WID_BITS-1:0]    wr_wid;
    csr_pkg::word_t                  wr_data;
    csr_pkg::fcsr_t                  fcsr_rd;
    logic [csr_pkg::CTR_BITS-1:0]    cycles;
    logic [csr_pkg::CTR_BITS-1:0]    instret;

    csr_ctrl #(
        .NUM_WARPS   (NUM_WARPS)
    ) u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .sel         (sel),
        .rdata       (rdata),
        .fcsr_wr_en  (fcsr_wr_en),
        .fcsr_wr_sel (fcsr_wr_sel),
        .wr_wid      (wr_wid),
        .wr_data     (wr_data)
    );

    fcsr_bank #(
        .NUM_WARPS   (NUM_WARPS)
    ) u_fcsr_bank (
        .clk         (clk),
        .reset       (reset),
        .fcsr_wr_en  (fcsr_wr_en),
        .fcsr_wr_sel (fcsr_wr_sel),
        .wr_wid      (wr_wid),
        .wr_data     (wr_data),
        .fpu_flags   (fpu_flags),
        .rd_wid      (bus_req.wid),
        .fcsr_rd     (fcsr_rd),
        .frm_wid     (frm_wid),
        .frm         (frm)
    );

    csr_counters u_counters (
        .clk         (clk),
        .reset       (reset),
        .commit      (commit),
        .cycles      (cycles),
        .instret     (instret)
    );

    csr_read_mux #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_THREADS  (NUM_THREADS),
        .CORE_ID      (CORE_ID),
        .NUM_CORES    (NUM_CORES)
    ) u_read_mux (
        .sel          (sel),
        .wid          (bus_req.wid),
        .fcsr_rd      (fcsr_rd),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .rdata        (rdata)
    );

endmodule

// ==== src/csr_ctrl.sv ====
// CSR Wishbone slave control
`timescale 1ns/1ps

module csr_ctrl #(
    parameter int NUM_WARPS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  csr_pkg::csr_req_t             bus_req,
    output csr_pkg::csr_rsp_t             bus_rsp,
    output csr_pkg::csr_sel_e             sel,
    input  csr_pkg::word_t                rdata,
    output logic                          fcsr_wr_en,
    output csr_pkg::csr_sel_e             fcsr_wr_sel,
    output logic [csr_pkg::WID_BITS-1:0]  wr_wid,
    output csr_pkg::word_t                wr_data
);

    csr_pkg::csr_state_e state_q;
    csr_pkg::csr_sel_e   dec_sel;
    logic                dec_writable;
    logic                access_ok;
    logic                accept;
    logic                is_fp;
    logic                ack_q;
    logic                err_q;
    csr_pkg::word_t      dat_q;

    always_comb begin
        dec_sel      = csr_pkg::SEL_NONE;
        dec_writable = 1'b0;
        case (bus_req.adr)
            csr_pkg::CSR_FFLAGS: begin
                dec_sel      = csr_pkg::SEL_FFLAGS;
                dec_writable = 1'b1;
            end
            csr_pkg::CSR_FRM: begin
                dec_sel      = csr_pkg::SEL_FRM;
                dec_writable = 1'b1;
            end
            csr_pkg::CSR_FCSR: begin
                dec_sel      = csr_pkg::SEL_FCSR;
                dec_writable = 1'b1;
            end
            csr_pkg::CSR_MVENDORID:   dec_sel = csr_pkg::SEL_VENDOR;
            csr_pkg::CSR_MARCHID:     dec_sel = csr_pkg::SEL_ARCH;
            csr_pkg::CSR_MIMPID:      dec_sel = csr_pkg::SEL_IMPL;
            csr_pkg::CSR_MISA:        dec_sel = csr_pkg::SEL_MISA;
            csr_pkg::CSR_WARP_ID:     dec_sel = csr_pkg::SEL_WARP_ID;
            csr_pkg::CSR_CORE_ID:     dec_sel = csr_pkg::SEL_CORE_ID;
            csr_pkg::CSR_THREAD_MASK: dec_sel = csr_pkg::SEL_THREAD_MASK;
            csr_pkg::CSR_WARP_MASK:   dec_sel = csr_pkg::SEL_WARP_MASK;
            csr_pkg::CSR_NUM_THREADS: dec_sel = csr_pkg::SEL_NUM_THREADS;
            csr_pkg::CSR_NUM_WARPS:   dec_sel = csr_pkg::SEL_NUM_WARPS;
            csr_pkg::CSR_NUM_CORES:   dec_sel = csr_pkg::SEL_NUM_CORES;
            csr_pkg::CSR_MCYCLE:      dec_sel = csr_pkg::SEL_CYCLE_LO;
            csr_pkg::CSR_MCYCLE_H:    dec_sel = csr_pkg::SEL_CYCLE_HI;
            csr_pkg::CSR_MINSTRET:    dec_sel = csr_pkg::SEL_INSTRET_LO;
            csr_pkg::CSR_MINSTRET_H:  dec_sel = csr_pkg::SEL_INSTRET_HI;
            // Stubs read zero and swallow writes
            csr_pkg::CSR_SATP, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MNSTATUS,
            csr_pkg::CSR_MEDELEG, csr_pkg::CSR_MIDELEG, csr_pkg::CSR_MIE,
            csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC, csr_pkg::CSR_PMPCFG0,
            csr_pkg::CSR_PMPADDR0: begin
                dec_sel      = csr_pkg::SEL_ZERO;
                dec_writable = 1'b1;
            end
            default: ;
        endcase
    end

    // Warp ids beyond the core's warp count are rejected too
    assign access_ok = (dec_sel != csr_pkg::SEL_NONE)
                     && (int'(bus_req.wid) < NUM_WARPS)
                     && (!bus_req.we || dec_writable);

    assign accept = (state_q == csr_pkg::ST_IDLE) && bus_req.cyc && bus_req.stb;
    assign is_fp  = (dec_sel == csr_pkg::SEL_FFLAGS) || (dec_sel == csr_pkg::SEL_FRM)
                 || (dec_sel == csr_pkg::SEL_FCSR);

    assign sel         = dec_sel;
    assign fcsr_wr_en  = accept && bus_req.we && access_ok && is_fp;
    assign fcsr_wr_sel = dec_sel;
    assign wr_wid      = bus_req.wid;
    assign wr_data     = bus_req.dat;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= csr_pkg::ST_IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else if (state_q == csr_pkg::ST_IDLE) begin
            if (accept) begin
                state_q <= csr_pkg::ST_RESPOND;
                ack_q   <= access_ok;
                err_q   <= !access_ok;
            end
        end else begin
            state_q <= csr_pkg::ST_IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end
    end

    // Read data captured before the write lands
    always_ff @(posedge clk) begin
        if (accept) begin
            dat_q <= access_ok ? rdata : '0;
        end
    end

    assign bus_rsp.ack = ack_q;
    assign bus_rsp.err = err_q;
    assign bus_rsp.dat = dat_q;

    a_ack_err_excl: assert property (@(posedge clk) disable iff (reset)
        !(bus_rsp.ack && bus_rsp.err));

    a_rsp_after_req: assert property (@(posedge clk) disable iff (reset)
        (bus_rsp.ack || bus_rsp.err) |-> $past(bus_req.cyc && bus_req.stb));

endmodule

// ==== src/csr_read_mux.sv ====
// CSR read data select
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int NUM_WARPS   = 4,
    parameter int NUM_THREADS = 4,
    parameter int CORE_ID     = 0,
    parameter int NUM_CORES   = 1
) (
    input  csr_pkg::csr_sel_e                      sel,
    input  logic [csr_pkg::WID_BITS-1:0]           wid,
    input  csr_pkg::fcsr_t                         fcsr_rd,
    input  logic [csr_pkg::CTR_BITS-1:0]           cycles,
    input  logic [csr_pkg::CTR_BITS-1:0]           instret,
    input  logic [NUM_WARPS-1:0]                   active_warps,
    input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0]  thread_masks,
    output csr_pkg::word_t                         rdata
);

    localparam int XL = csr_pkg::XLEN;
    localparam int CB = csr_pkg::CTR_BITS;

    logic [NUM_THREADS-1:0] wid_mask;

    always_comb begin
        wid_mask = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (int'(wid) == i) begin
                wid_mask = thread_masks[i];
            end
        end
    end

    always_comb begin
        case (sel)
            csr_pkg::SEL_FFLAGS:      rdata = csr_pkg::word_t'(fcsr_rd.fflags);
            csr_pkg::SEL_FRM:         rdata = csr_pkg::word_t'(fcsr_rd.frm);
            csr_pkg::SEL_FCSR:        rdata = csr_pkg::word_t'(fcsr_rd);
            csr_pkg::SEL_VENDOR:      rdata = csr_pkg::VENDOR_ID;
            csr_pkg::SEL_ARCH:        rdata = csr_pkg::ARCH_ID;
            csr_pkg::SEL_IMPL:        rdata = csr_pkg::IMPL_ID;
            csr_pkg::SEL_MISA:        rdata = csr_pkg::MISA_VALUE;
            csr_pkg::SEL_WARP_ID:     rdata = csr_pkg::word_t'(wid);
            csr_pkg::SEL_CORE_ID:     rdata = csr_pkg::word_t'(CORE_ID);
            csr_pkg::SEL_THREAD_MASK: rdata = csr_pkg::word_t'(wid_mask);
            csr_pkg::SEL_WARP_MASK:   rdata = csr_pkg::word_t'(active_warps);
            csr_pkg::SEL_NUM_THREADS: rdata = csr_pkg::word_t'(NUM_THREADS);
            csr_pkg::SEL_NUM_WARPS:   rdata = csr_pkg::word_t'(NUM_WARPS);
            csr_pkg::SEL_NUM_CORES:   rdata = csr_pkg::word_t'(NUM_CORES);
            csr_pkg::SEL_CYCLE_LO:    rdata = cycles[XL-1:0];
            csr_pkg::SEL_CYCLE_HI:    rdata = cycles[CB-1:XL];
            csr_pkg::SEL_INSTRET_LO:  rdata = instret[XL-1:0];
            csr_pkg::SEL_INSTRET_HI:  rdata = instret[CB-1:XL];
            // Stubs and unmapped addresses
            default:                  rdata = '0;
        endcase
    end

endmodule

// ==== src/fcsr_bank.sv ====
// Per-warp floating-point CSR bank
`timescale 1ns/1ps

module fcsr_bank #(
    parameter int NUM_WARPS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fcsr_wr_en,
    input  csr_pkg::csr_sel_e             fcsr_wr_sel,
    input  logic [csr_pkg::WID_BITS-1:0]  wr_wid,
    input  csr_pkg::word_t                wr_data,
    input  csr_pkg::fpu_flags_t           fpu_flags,
    input  logic [csr_pkg::WID_BITS-1:0]  rd_wid,
    output csr_pkg::fcsr_t                fcsr_rd,
    input  logic [csr_pkg::WID_BITS-1:0]  frm_wid,
    output logic [csr_pkg::FRM_BITS-1:0]  frm
);

    csr_pkg::fcsr_t fcsr_q [NUM_WARPS];
    csr_pkg::fcsr_t fcsr_n [NUM_WARPS];

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            fcsr_n[i] = fcsr_q[i];
            // Sticky exception flags from the FPU
            if (fpu_flags.valid && int'(fpu_flags.wid) == i) begin
                fcsr_n[i].fflags = fcsr_q[i].fflags | fpu_flags.fflags;
            end
            // Bus write overrides the bits it covers
            if (fcsr_wr_en && int'(wr_wid) == i) begin
                case (fcsr_wr_sel)
                    csr_pkg::SEL_FFLAGS: fcsr_n[i].fflags = wr_data[csr_pkg::FFLAGS_BITS-1:0];
                    csr_pkg::SEL_FRM:    fcsr_n[i].frm = wr_data[csr_pkg::FRM_BITS-1:0];
                    csr_pkg::SEL_FCSR:   fcsr_n[i] = wr_data[$bits(csr_pkg::fcsr_t)-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (reset) begin
                fcsr_q[i] <= '0;
            end else begin
                fcsr_q[i] <= fcsr_n[i];
            end
        end
    end

    always_comb begin
        fcsr_rd = '0;
        frm     = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (int'(rd_wid) == i) begin
                fcsr_rd = fcsr_q[i];
            end
            if (int'(frm_wid) == i) begin
                frm = fcsr_q[i].frm;
            end
        end
    end

    a_wid_in_range: assert property (@(posedge clk) disable iff (reset)
        (!fpu_flags.valid || int'(fpu_flags.wid) < NUM_WARPS)
        && (!fcsr_wr_en || int'(wr_wid) < NUM_WARPS));

endmodule

// ==== src/csr_counters.sv ====
// Cycle and retired-instruction counters
`timescale 1ns/1ps

module csr_counters (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          commit,
    output logic [csr_pkg::CTR_BITS-1:0]  cycles,
    output logic [csr_pkg::CTR_BITS-1:0]  instret
);

    logic [csr_pkg::CTR_BITS-1:0] cycles_q;
    logic [csr_pkg::CTR_BITS-1:0] instret_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_q  <= '0;
            instret_q <= '0;
        end else begin
            cycles_q <= cycles_q + 1'b1;
            if (commit) begin
                instret_q <= instret_q + 1'b1;
            end
        end
    end

    assign cycles  = cycles_q;
    assign instret = instret_q;

endmodule

// ==== src/csr_pkg.sv ====
// GPU core CSR definitions
package csr_pkg;

    localparam int CSR_ADDR_BITS = 12;
    localparam int XLEN          = 32;
    localparam int CTR_BITS      = 64;
    localparam int FFLAGS_BITS   = 5;
    localparam int FRM_BITS      = 3;
    localparam int WID_BITS      = 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;

    // Floating-point
    localparam csr_addr_t CSR_FFLAGS      = 12'h001;
    localparam csr_addr_t CSR_FRM         = 12'h002;
    localparam csr_addr_t CSR_FCSR        = 12'h003;

    // Machine mode
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MISA        = 12'h301;
    localparam csr_addr_t CSR_MEDELEG     = 12'h302;
    localparam csr_addr_t CSR_MIDELEG     = 12'h303;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MTVEC       = 12'h305;
    localparam csr_addr_t CSR_MEPC        = 12'h341;
    localparam csr_addr_t CSR_SATP        = 12'h180;
    localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS    = 12'h744;

    // Counters
    localparam csr_addr_t CSR_MCYCLE      = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET    = 12'hB02;
    localparam csr_addr_t CSR_MCYCLE_H    = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET_H  = 12'hB82;

    // GPU specific
    localparam csr_addr_t CSR_WARP_ID     = 12'hCC1;
    localparam csr_addr_t CSR_CORE_ID     = 12'hCC2;
    localparam csr_addr_t CSR_WARP_MASK   = 12'hCC3;
    localparam csr_addr_t CSR_THREAD_MASK = 12'hCC4;

    localparam csr_addr_t CSR_MVENDORID   = 12'hF11;
    localparam csr_addr_t CSR_MARCHID     = 12'hF12;
    localparam csr_addr_t CSR_MIMPID      = 12'hF13;

    localparam csr_addr_t CSR_NUM_THREADS = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS   = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES   = 12'hFC2;

    localparam word_t VENDOR_ID  = 32'h0000_0000;
    localparam word_t ARCH_ID    = 32'h0000_0001;
    localparam word_t IMPL_ID    = 32'h0000_0001;
    // MXL=1 (RV32) with I, M and F
    localparam word_t MISA_VALUE = 32'h4000_1120;

    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_FFLAGS,
        SEL_FRM,
        SEL_FCSR,
        SEL_VENDOR,
        SEL_ARCH,
        SEL_IMPL,
        SEL_MISA,
        SEL_WARP_ID,
        SEL_CORE_ID,
        SEL_THREAD_MASK,
        SEL_WARP_MASK,
        SEL_NUM_THREADS,
        SEL_NUM_WARPS,
        SEL_NUM_CORES,
        SEL_CYCLE_LO,
        SEL_CYCLE_HI,
        SEL_INSTRET_LO,
        SEL_INSTRET_HI,
        SEL_ZERO
    } csr_sel_e;

    typedef enum logic {
        ST_IDLE,
        ST_RESPOND
    } csr_state_e;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WID_BITS-1:0] wid;
        csr_addr_t           adr;
        word_t               dat;
    } csr_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } csr_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic [WID_BITS-1:0]    wid;
        logic [FFLAGS_BITS-1:0] fflags;
    } fpu_flags_t;

    typedef struct packed {
        logic [FRM_BITS-1:0]    frm;
        logic [FFLAGS_BITS-1:0] fflags;
    } fcsr_t;

endpackage
